// ==== compile.f ====
hw/isa_pkg.sv
hw/core_pkg.sv
hw/insn_decoder.sv
hw/reg_file.sv
hw/scalar_alu.sv
hw/vector_alu.sv
hw/exec_stage.sv
hw/core_top.sv
test/tb_core_top.sv

// ==== hw/core_pkg.sv ====
// internal control encodings of the execute core
// unit select and the operation codes of the scalar and vector units
`default_nettype none

package core_pkg;

  typedef enum logic {
    UNIT_SCALAR = 1'b0,
    UNIT_VECTOR = 1'b1
  } unit_e;

  // scalar alu operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'b001,
    ALU_SUB = 3'b010,
    ALU_AND = 3'b011,
    ALU_OR  = 3'b100,
    ALU_MUL = 3'b110
  } alu_op_e;

  // packed vector operations
  typedef enum logic [1:0] {
    VALU_ADD = 2'b00,
    VALU_SUB = 2'b01,
    VALU_DOT = 2'b10
  } valu_op_e;

endpackage

`default_nettype wire

// ==== hw/core_top.sv ====
// top of the execute core: decoder, register file and execute stage
// one instruction per valid cycle, write-back reported one cycle later
`default_nettype none
`timescale 1ns/10ps

module core_top import isa_pkg::*, core_pkg::*; (
  input  logic      clk_i,
  input  logic      start_i,       // async, active low
  input  word_t     instr_i,
  input  logic      instr_valid_i,
  input  reg_addr_t dbg_addr_i,
  output logic      wb_valid_o,
  output reg_addr_t wb_addr_o,
  output word_t     wb_data_o,
  output word_t     dbg_data_o
);

  reg_addr_t rs1_addr, rs2_addr, rd_addr;
  word_t     rs1_data, rs2_data, imm;
  logic      use_imm, reg_write;
  unit_e     unit;
  alu_op_e   alu_op;
  valu_op_e  valu_op;

  insn_decoder u_decoder (
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rd_addr_o     (rd_addr),
    .imm_o         (imm),
    .use_imm_o     (use_imm),
    .reg_write_o   (reg_write),
    .unit_o        (unit),
    .alu_op_o      (alu_op),
    .valu_op_o     (valu_op)
  );

  // write port fed from the execute stage's result
  reg_file u_reg_file (
    .clk_i      (clk_i),
    .start_i    (start_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .dbg_addr_i (dbg_addr_i),
    .wr_addr_i  (wb_addr_o),
    .wr_data_i  (wb_data_o),
    .wr_en_i    (wb_valid_o),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .dbg_data_o (dbg_data_o)
  );

  exec_stage u_exec_stage (
    .clk_i      (clk_i),
    .start_i    (start_i),
    .valid_i    (reg_write),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rd_addr_i  (rd_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .imm_i      (imm),
    .use_imm_i  (use_imm),
    .unit_i     (unit),
    .alu_op_i   (alu_op),
    .valu_op_i  (valu_op),
    .wb_valid_o (wb_valid_o),
    .wb_addr_o  (wb_addr_o),
    .wb_data_o  (wb_data_o)
  );

endmodule

`default_nettype wire

// ==== hw/exec_stage.sv ====
// execute stage: ID/EX register, one level of forwarding and the two units
// the write-back port is driven straight from this stage's result
`default_nettype none
`timescale 1ns/10ps

module exec_stage import isa_pkg::*, core_pkg::*; (
  input  logic      clk_i,
  input  logic      start_i,
  input  logic      valid_i,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  input  reg_addr_t rd_addr_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  input  word_t     imm_i,
  input  logic      use_imm_i,
  input  unit_e     unit_i,
  input  alu_op_e   alu_op_i,
  input  valu_op_e  valu_op_i,
  output logic      wb_valid_o,
  output reg_addr_t wb_addr_o,
  output word_t     wb_data_o
);

  logic      fwd_rs1, fwd_rs2;
  word_t     rs1_fwd, rs2_fwd;

  logic      valid_q;
  reg_addr_t rd_q;
  word_t     rs1_q, rs2_q, imm_q;
  logic      use_imm_q;
  unit_e     unit_q;
  alu_op_e   alu_op_q;
  valu_op_e  valu_op_q;

  word_t     op_b;
  word_t     scalar_res, vector_res;

  ////////////////////////////////////////////////////////////
  // forwarding
  // the register file commits at the same edge that captures the next
  // instruction, so its old value is replaced by our own result here
  assign fwd_rs1 = wb_valid_o && (wb_addr_o != '0) && (wb_addr_o == rs1_addr_i);
  assign fwd_rs2 = wb_valid_o && (wb_addr_o != '0) && (wb_addr_o == rs2_addr_i);

  assign rs1_fwd = fwd_rs1 ? wb_data_o : rs1_data_i;
  assign rs2_fwd = fwd_rs2 ? wb_data_o : rs2_data_i;

  ////////////////////////////////////////////////////////////
  // ID/EX register
  always_ff @(posedge clk_i or negedge start_i) begin
    if (!start_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q      <= rd_addr_i;
    rs1_q     <= rs1_fwd;
    rs2_q     <= rs2_fwd;
    imm_q     <= imm_i;
    use_imm_q <= use_imm_i;
    unit_q    <= unit_i;
    alu_op_q  <= alu_op_i;
    valu_op_q <= valu_op_i;
  end

  ////////////////////////////////////////////////////////////
  // execute
  assign op_b = use_imm_q ? imm_q : rs2_q; // addi / lui take the immediate

  scalar_alu u_scalar_alu (
    .a_i  (rs1_q),
    .b_i  (op_b),
    .op_i (alu_op_q),
    .y_o  (scalar_res)
  );

  vector_alu u_vector_alu (
    .a_i  (rs1_q),
    .b_i  (op_b),
    .op_i (valu_op_q),
    .y_o  (vector_res)
  );

  assign wb_valid_o = valid_q;
  assign wb_addr_o  = rd_q;
  assign wb_data_o  = (unit_q == UNIT_VECTOR) ? vector_res : scalar_res;

endmodule

`default_nettype wire

// ==== hw/insn_decoder.sv ====
// instruction decoder of the execute core, purely combinational
// gives register addresses, immediate and unit/op controls for one word
`default_nettype none
`timescale 1ns/10ps

module insn_decoder import isa_pkg::*, core_pkg::*; (
  input  word_t     instr_i,
  input  logic      instr_valid_i,
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  output reg_addr_t rd_addr_o,
  output word_t     imm_o,
  output logic      use_imm_o,
  output logic      reg_write_o,
  output unit_e     unit_o,
  output alu_op_e   alu_op_o,
  output valu_op_e  valu_op_o
);

  opcode_e    opcode;
  logic [9:0] funct; // funct7/funct6+vm with funct3

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct  = {instr_i[31:25], instr_i[14:12]};

  assign rs2_addr_o = instr_i[24:20];
  assign rd_addr_o  = instr_i[11:7];

  always_comb begin
    // defaults suit an r-type add
    rs1_addr_o  = instr_i[19:15];
    imm_o       = {{(XLEN-IMM_I_W){instr_i[31]}}, instr_i[31:20]};
    use_imm_o   = 1'b0;
    reg_write_o = 1'b0;
    unit_o      = UNIT_SCALAR;
    alu_op_o    = ALU_ADD;
    valu_op_o   = VALU_ADD;

    case (opcode)
      OPC_OP_IMM: begin
        use_imm_o   = 1'b1;
        reg_write_o = instr_valid_i;
      end
      OPC_LUI: begin
        rs1_addr_o  = '0; // x0 + upper imm
        imm_o       = {instr_i[31:IMM_I_W], {IMM_I_W{1'b0}}};
        use_imm_o   = 1'b1;
        reg_write_o = instr_valid_i;
      end
      OPC_OP: begin
        reg_write_o = instr_valid_i;
        case (funct)
          FUNCT_SUB: alu_op_o = ALU_SUB;
          FUNCT_MUL: alu_op_o = ALU_MUL;
          FUNCT_OR:  alu_op_o = ALU_OR;
          FUNCT_AND: alu_op_o = ALU_AND;
          default:   alu_op_o = ALU_ADD; // FUNCT_ADD and unknown codes
        endcase
      end
      OPC_VECTOR: begin
        reg_write_o = instr_valid_i;
        unit_o      = UNIT_VECTOR;
        case (funct)
          VFUNCT_VSUB: valu_op_o = VALU_SUB;
          VFUNCT_VDOT: valu_op_o = VALU_DOT;
          default:     valu_op_o = VALU_ADD; // VFUNCT_VADD and unknown
        endcase
      end
      default: ; // unknown opcode writes nothing
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/isa_pkg.sv ====
// instruction-set definitions shared by decoder, register file and testbench
// field widths, opcode and funct encodings, word and register address types
`default_nettype none

package isa_pkg;

  localparam int XLEN       = 32; // data word width
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int IMM_I_W    = 12; // i-type immediate
  localparam int LANE_W     = 8;  // one packed vector lane
  localparam int NUM_LANES  = 4;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011, // addi
    OPC_OP     = 7'b0110011, // r-type
    OPC_LUI    = 7'b0110111,
    OPC_VECTOR = 7'b1010111
  } opcode_e;

  // scalar {funct7, funct3}
  localparam logic [9:0] FUNCT_ADD = 10'b0000000_000;
  localparam logic [9:0] FUNCT_SUB = 10'b0100000_000;
  localparam logic [9:0] FUNCT_MUL = 10'b0000001_000;
  localparam logic [9:0] FUNCT_OR  = 10'b0000000_110;
  localparam logic [9:0] FUNCT_AND = 10'b0000000_111;

  // vector {funct6, vm, funct3}
  localparam logic [9:0] VFUNCT_VADD = 10'b000000_1_001;
  localparam logic [9:0] VFUNCT_VSUB = 10'b010000_1_000;
  localparam logic [9:0] VFUNCT_VDOT = 10'b000000_1_110;

endpackage

`default_nettype wire

// ==== hw/reg_file.sv ====
// 32 x 32-bit register file, two operand reads and one debug read
// reads are combinational, the single write port commits on the rising edge
`default_nettype none
`timescale 1ns/10ps

module reg_file import isa_pkg::*; (
  input  logic      clk_i,
  input  logic      start_i,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  input  reg_addr_t dbg_addr_i,
  input  reg_addr_t wr_addr_i,
  input  word_t     wr_data_i,
  input  logic      wr_en_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o,
  output word_t     dbg_data_o
);

  word_t regs [NUM_REGS];

  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];
  assign dbg_data_o = regs[dbg_addr_i];

  // x0 is never written, so it stays at its reset value of zero
  always_ff @(posedge clk_i or negedge start_i) begin
    if (!start_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/scalar_alu.sv ====
// 32-bit scalar alu of the execute stage
// add, sub, and, or and a low-word multiply
`default_nettype none
`timescale 1ns/10ps

module scalar_alu import isa_pkg::*, core_pkg::*; (
  input  word_t   a_i,
  input  word_t   b_i,
  input  alu_op_e op_i,
  output word_t   y_o
);

  always_comb begin
    case (op_i)
      ALU_ADD: y_o = a_i + b_i;
      ALU_SUB: y_o = a_i - b_i;
      ALU_AND: y_o = a_i & b_i;
      ALU_OR:  y_o = a_i | b_i;
      ALU_MUL: y_o = a_i * b_i; // low word only
      default: y_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/vector_alu.sv ====
// packed vector alu, four signed 8-bit lanes in one word
// lane-wise wrapping add and subtract, plus a signed dot product
`default_nettype none
`timescale 1ns/10ps

module vector_alu import isa_pkg::*, core_pkg::*; (
  input  word_t    a_i,
  input  word_t    b_i,
  input  valu_op_e op_i,
  output word_t    y_o
);

  logic signed [LANE_W-1:0] lane_a [NUM_LANES];
  logic signed [LANE_W-1:0] lane_b [NUM_LANES];
  logic signed [XLEN-1:0]   prod   [NUM_LANES];
  word_t                    vsum;
  word_t                    vdiff;
  logic signed [XLEN-1:0]   dot;

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane_a[g] = a_i[g*LANE_W +: LANE_W]; // lane 0 in low byte
    assign lane_b[g] = b_i[g*LANE_W +: LANE_W];
    assign vsum[g*LANE_W +: LANE_W]  = lane_a[g] + lane_b[g]; // wraps in lane
    assign vdiff[g*LANE_W +: LANE_W] = lane_a[g] - lane_b[g];
    assign prod[g] = $signed({{(XLEN-LANE_W){lane_a[g][LANE_W-1]}}, lane_a[g]}) *
                     $signed({{(XLEN-LANE_W){lane_b[g][LANE_W-1]}}, lane_b[g]});
  end

  // sum of the four lane products
  always_comb begin
    dot = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      dot = dot + prod[i];
    end
  end

  always_comb begin
    case (op_i)
      VALU_ADD: y_o = vsum;
      VALU_SUB: y_o = vdiff;
      VALU_DOT: y_o = dot;
      default:  y_o = vsum;
    endcase
  end

endmodule

`default_nettype wire

// ==== test/tb_core_top.sv ====
// directed testbench for the execute core
// a register model predicts every write-back and a monitor checks each one
`default_nettype none
`timescale 1ns/10ps

module tb_core_top import isa_pkg::*, core_pkg::*;;

  logic      clk_i;
  logic      start_i;
  word_t     instr_i;
  logic      instr_valid_i;
  reg_addr_t dbg_addr_i;
  logic      wb_valid_o;
  reg_addr_t wb_addr_o;
  word_t     wb_data_o;
  word_t     dbg_data_o;

  word_t       model [NUM_REGS]; // expected register contents
  word_t       exp_data [$];
  reg_addr_t   exp_addr [$];
  int          exp_cyc [$];      // issue cycle of each pending write-back
  int          cycle = 0;
  int unsigned rnd_init;
  word_t       limit_vals [4] = '{32'h7F80_FF01, 32'h8080_7F7F, 32'h7F7F_8080, 32'hFF01_807F};

  core_top dut0 (
    .clk_i         (clk_i),
    .start_i       (start_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .dbg_addr_i    (dbg_addr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_addr_o     (wb_addr_o),
    .wb_data_o     (wb_data_o),
    .dbg_data_o    (dbg_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i; // 40 ns period
    end
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  ////////////////////////////////////////////////////////////
  // failure reporting and typed compares
  task automatic report_fail(string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) report_fail($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) report_fail($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) report_fail($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  function automatic word_t scalar_ref(logic [9:0] funct, word_t a, word_t b);
    case (funct)
      FUNCT_SUB: return a - b;
      FUNCT_MUL: return a * b; // low word
      FUNCT_OR:  return a | b;
      FUNCT_AND: return a & b;
      default:   return a + b;
    endcase
  endfunction

  function automatic word_t vector_ref(logic [9:0] funct, word_t a, word_t b);
    logic signed [LANE_W-1:0] la;
    logic signed [LANE_W-1:0] lb;
    int                       acc;
    word_t                    res;
    acc = 0;
    res = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      la = a[i*LANE_W +: LANE_W];
      lb = b[i*LANE_W +: LANE_W];
      if (funct == VFUNCT_VSUB) begin
        res[i*LANE_W +: LANE_W] = la - lb; // truncation gives the lane wrap
      end else begin
        res[i*LANE_W +: LANE_W] = la + lb;
      end
      acc = acc + int'(la) * int'(lb);
    end
    return (funct == VFUNCT_VDOT) ? word_t'(acc) : res;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus
  task automatic issue(word_t w, logic writes, reg_addr_t rd, word_t val);
    @(posedge clk_i);
    #2;
    instr_i       = w;
    instr_valid_i = 1'b1;
    if (writes) begin
      exp_cyc.push_back(cycle);
      exp_addr.push_back(rd);
      exp_data.push_back(val);
      if (rd != '0) model[rd] = val; // x0 stays zero
    end
  endtask

  task automatic do_lui(reg_addr_t rd, logic [XLEN-IMM_I_W-1:0] upper);
    issue({upper, rd, OPC_LUI}, 1'b1, rd, {upper, {IMM_I_W{1'b0}}});
  endtask

  task automatic do_addi(reg_addr_t rd, reg_addr_t rs1, logic [IMM_I_W-1:0] imm);
    issue({imm, rs1, 3'b000, rd, OPC_OP_IMM}, 1'b1, rd,
          model[rs1] + {{(XLEN-IMM_I_W){imm[IMM_I_W-1]}}, imm});
  endtask

  task automatic do_rtype(logic [9:0] funct, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    issue({funct[9:3], rs2, rs1, funct[2:0], rd, OPC_OP}, 1'b1, rd,
          scalar_ref(funct, model[rs1], model[rs2]));
  endtask

  task automatic do_vector(logic [9:0] funct, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    issue({funct[9:3], rs2, rs1, funct[2:0], rd, OPC_VECTOR}, 1'b1, rd,
          vector_ref(funct, model[rs1], model[rs2]));
  endtask

  // upper part rounded up when bit 11 is set so the addi sign extension cancels it
  task automatic load_word(reg_addr_t rd, word_t v);
    do_lui(rd, v[XLEN-1:IMM_I_W] + v[IMM_I_W-1]);
    do_addi(rd, rd, v[IMM_I_W-1:0]);
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
      instr_valid_i = 1'b0;
      instr_i       = $urandom; // junk on the bus with the strobe low
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    idle(1);
    while (exp_cyc.size() > 0) begin
      @(posedge clk_i);
      waited++;
      if (waited > 20) report_fail("timeout: expected write-backs never arrived");
    end
  endtask

  task automatic check_reg(reg_addr_t r);
    @(posedge clk_i);
    #2;
    dbg_addr_i = r;
    #1;
    check_word("dbg_data_o", dbg_data_o, model[r]);
  endtask

  // every write-back lands one cycle after its issue and in no other cycle
  initial begin : wb_monitor
    forever begin
      @(negedge clk_i);
      if (exp_cyc.size() > 0 && exp_cyc[0] + 1 == cycle) begin
        check_bit("wb_valid_o", wb_valid_o, 1'b1);
        check_addr("wb_addr_o", wb_addr_o, exp_addr.pop_front());
        check_word("wb_data_o", wb_data_o, exp_data.pop_front());
        exp_cyc.delete(0);
      end else begin
        check_bit("wb_valid_o", wb_valid_o, 1'b0);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // directed tests
  task automatic test_reset();
    reg_addr_t sample [4] = '{5'd0, 5'd1, 5'd15, 5'd31};
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      #2;
      dbg_addr_i = sample[i];
      #1;
      check_word("dbg_data_o", dbg_data_o, 32'h0);
    end
  endtask

  task automatic rtype_checked(logic [9:0] funct, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    do_rtype(funct, rd, rs1, rs2);
    drain();
    check_reg(rd);
  endtask

  task automatic test_scalar();
    for (int r = 1; r <= 4; r++) load_word(reg_addr_t'(r), $urandom);
    drain();
    for (int r = 1; r <= 4; r++) check_reg(reg_addr_t'(r));
    rtype_checked(FUNCT_ADD, 5, 1, 2);
    rtype_checked(FUNCT_SUB, 6, 1, 2);
    rtype_checked(FUNCT_AND, 7, 3, 4);
    rtype_checked(FUNCT_OR,  8, 3, 4);
    rtype_checked(FUNCT_MUL, 9, 3, 4);
  endtask

  task automatic test_forwarding();
    do_rtype(FUNCT_ADD, 10, 1, 2);
    do_rtype(FUNCT_SUB, 11, 10, 3);  // rs1 from previous
    do_rtype(FUNCT_MUL, 12, 4, 11);  // rs2 from previous
    do_rtype(FUNCT_OR, 13, 12, 12);  // both operands
    do_addi(13, 13, 12'hFFB);
    do_vector(VFUNCT_VADD, 14, 13, 1);
    do_vector(VFUNCT_VDOT, 15, 14, 14);
    load_word(16, $urandom);
    do_rtype(FUNCT_AND, 17, 16, 15);
    drain();
    for (int r = 10; r <= 17; r++) check_reg(reg_addr_t'(r));
  endtask

  task automatic test_vector();
    for (int i = 0; i < 8; i++) begin
      load_word(21, (i < 4) ? limit_vals[i] : word_t'($urandom));
      load_word(22, (i < 4) ? limit_vals[3-i] : word_t'($urandom));
      do_vector(VFUNCT_VADD, 23, 21, 22);
      do_vector(VFUNCT_VSUB, 24, 21, 22);
      do_vector(VFUNCT_VDOT, 25, 21, 22);
      drain();
      for (int r = 23; r <= 25; r++) check_reg(reg_addr_t'(r));
    end
  endtask

  task automatic test_no_write();
    do_addi(0, 1, 12'h007);          // pulses with rd = 0
    do_rtype(FUNCT_ADD, 20, 0, 1);   // x0 must not be forwarded
    issue({25'h1A5_5A5A, 7'b1111111}, 1'b0, '0, '0); // unknown opcode
    drain();
    check_reg(0);
    check_reg(20);
  endtask

  task automatic test_gaps();
    do_addi(26, 0, 12'h123);
    idle(3);
    do_rtype(FUNCT_ADD, 27, 26, 26);
    idle(2);
    do_vector(VFUNCT_VSUB, 28, 27, 26);
    drain();
    for (int r = 26; r <= 28; r++) check_reg(reg_addr_t'(r));
  endtask

  initial begin
    rnd_init      = $urandom(72);
    start_i       = 1'b0;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    dbg_addr_i    = '0;
    for (int r = 0; r < NUM_REGS; r++) model[r] = '0;
    repeat (3) @(posedge clk_i);
    check_bit("wb_valid_o", wb_valid_o, 1'b0);
    #2;
    start_i = 1'b1;
    test_reset();
    test_scalar();
    test_forwarding();
    test_vector();
    test_no_write();
    test_gaps();
    for (int r = 0; r < NUM_REGS; r++) check_reg(reg_addr_t'(r)); // whole file
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
